// File: design/lsq_consts.svh
`ifndef LSQ_CONSTS_SVH
`define LSQ_CONSTS_SVH

// Load buffer depth as a power of two
`define LB_SIZE 8

// Width of instruction and load sequence numbers
`define SQN_WIDTH 7

// Most entries the buffer can retire in one cycle
`define COMMIT_WIDTH 4

// Byte offsets of the control registers
`define REG_MMIO_BASE 32'h0000_0000
`define REG_MMIO_MASK 32'h0000_0004
`define REG_COLL_CNT 32'h0000_0008
`define REG_DELAY_CNT 32'h0000_000C

`endif

// File: design/lsqPkg.sv
`include "lsq_consts.svh"

package lsqPkg;

    // Sequence numbers wrap, so order is taken from the signed difference
    typedef logic [`SQN_WIDTH-1:0] sqN_t;

    // Memory op leaving address generation. Size is 0 byte, 1 half, 2 word
    typedef struct packed {
        logic        valid;
        sqN_t        sqN;
        sqN_t        loadSqN;
        logic [31:0] addr;
        logic [1:0]  size;
        logic        signExtend;
        logic [5:0]  tagDst;
        logic [31:0] pc;
        logic        compressed;
    } aguUop_t;

    // Load request towards the data cache
    typedef struct packed {
        logic        valid;
        sqN_t        sqN;
        sqN_t        loadSqN;
        logic [31:0] addr;
        logic [1:0]  size;
        logic        signExtend;
        logic [5:0]  tagDst;
        logic        isMmio;
    } ldUop_t;

    // Cache answer for an issued load. A set fail bit asks for a replay
    typedef struct packed {
        logic valid;
        logic fail;
        sqN_t loadSqN;
    } ldAck_t;

    typedef struct packed {
        logic        taken;
        logic        flush;
        sqN_t        sqN;
        sqN_t        loadSqN;
        logic [31:0] dstPc;
    } branchProv_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axiResp_e;

endpackage

// File: design/lsqCfgIf.sv
`timescale 1ns/100ps

// Configuration and event lines between the register block and the load buffer
interface lsqCfgIf;

    // Loads whose masked address equals the base are treated as non-speculative
    logic [31:0] mmioBase;
    logic [31:0] mmioMask;

    // Single-cycle pulses counted by the register block
    logic collisionEvt;
    logic delayEvt;

    modport regs (
        output mmioBase,
        output mmioMask,
        input  collisionEvt,
        input  delayEvt
    );

    modport buffer (
        input  mmioBase,
        input  mmioMask,
        output collisionEvt,
        output delayEvt
    );

endinterface

// File: design/loadBuffer.sv
`timescale 1ns/100ps
`include "lsq_consts.svh"

module loadBuffer (
    input  logic                clk,
    input  logic                rst,
    input  lsqPkg::sqN_t        commitSqN,
    input  logic                sqDone,
    input  logic                stall,
    input  lsqPkg::aguUop_t     loadIn,
    input  lsqPkg::aguUop_t     storeIn,
    input  lsqPkg::ldAck_t      ldAck,
    input  lsqPkg::branchProv_t branchIn,
    output lsqPkg::ldUop_t      aguLoad,
    output lsqPkg::ldUop_t      lateLoad,
    output logic                isDelayLoad,
    output lsqPkg::branchProv_t branchOut,
    output lsqPkg::sqN_t        maxLoadSqN,
    lsqCfgIf.buffer             cfg
);

    localparam int Depth = `LB_SIZE;
    localparam int IdxW = $clog2(Depth);
    localparam int CntW = $clog2(`COMMIT_WIDTH + 1);

    typedef struct packed {
        lsqPkg::sqN_t sqN;
        lsqPkg::sqN_t loadSqN;
        logic [5:0]   tagDst;
        logic [31:0]  addr;
        logic [1:0]   size;
        logic         signExtend;
        logic         nonSpec;
    } entry_t;

    entry_t entries [Depth];
    logic [Depth-1:0] entValid;
    logic [Depth-1:0] entIssued;

    lsqPkg::sqN_t head;
    lsqPkg::sqN_t headNext;
    logic [IdxW-1:0] headIdx;
    logic [IdxW-1:0] insIdx;
    logic [IdxW-1:0] ackIdx;

    lsqPkg::ldUop_t lateUop;
    logic lateValid;
    lsqPkg::branchProv_t rollback;
    logic rollbackTaken;

    logic inWindow;
    logic overlapsStore;
    logic delayLoad;
    logic insertEn;
    logic storeLive;
    logic storeHit;
    logic collisionNow;
    logic lateIssue;
    logic [Depth-1:0] retireMask;
    logic [Depth-1:0] killMask;
    logic [CntW-1:0] retireCnt;

    function automatic logic signed [`SQN_WIDTH-1:0] sqnDiff(
        input lsqPkg::sqN_t a,
        input lsqPkg::sqN_t b
    );
        return a - b;
    endfunction

    // Bytes touched within the aligned word
    function automatic logic [3:0] byteMask(input logic [1:0] addrLo, input logic [1:0] size);
        logic [3:0] mask;
        case (size)
            2'd0: mask = 4'b0001 << addrLo;
            2'd1: mask = addrLo[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    function automatic logic accessOverlap(
        input logic [31:0] addrA,
        input logic [1:0]  sizeA,
        input logic [31:0] addrB,
        input logic [1:0]  sizeB
    );
        return (addrA[31:2] == addrB[31:2]) &&
            |(byteMask(addrA[1:0], sizeA) & byteMask(addrB[1:0], sizeB));
    endfunction

    assign headIdx = head[IdxW-1:0];
    assign insIdx = loadIn.loadSqN[IdxW-1:0];
    assign ackIdx = ldAck.loadSqN[IdxW-1:0];

    assign inWindow = (loadIn.addr & cfg.mmioMask) == cfg.mmioBase;

    // An older store in the same cycle cannot forward yet, so the load waits
    assign overlapsStore = storeIn.valid &&
        sqnDiff(storeIn.loadSqN, loadIn.loadSqN) <= 0 &&
        accessOverlap(storeIn.addr, storeIn.size, loadIn.addr, loadIn.size);

    assign delayLoad = inWindow || overlapsStore;
    assign isDelayLoad = loadIn.valid && delayLoad;

    // Ops not older than a same-cycle branch are already dead
    assign insertEn = loadIn.valid &&
        (!branchIn.taken || sqnDiff(loadIn.sqN, branchIn.sqN) < 0);
    assign storeLive = storeIn.valid &&
        (!branchIn.taken || sqnDiff(storeIn.sqN, branchIn.sqN) < 0);

    assign collisionNow = storeLive && storeHit;
    assign cfg.collisionEvt = collisionNow;
    assign cfg.delayEvt = insertEn && delayLoad;

    always_comb begin
        aguLoad.valid = loadIn.valid && !delayLoad;
        aguLoad.sqN = loadIn.sqN;
        aguLoad.loadSqN = loadIn.loadSqN;
        aguLoad.addr = loadIn.addr;
        aguLoad.size = loadIn.size;
        aguLoad.signExtend = loadIn.signExtend;
        aguLoad.tagDst = loadIn.tagDst;
        aguLoad.isMmio = inWindow;
    end

    // A store that hits any issued younger load sends the core back past the store
    always_comb begin
        storeHit = 1'b0;
        for (int i = 0; i < Depth; i++) begin
            if (entValid[i] && entIssued[i] &&
                sqnDiff(storeIn.loadSqN, entries[i].loadSqN) <= 0 &&
                accessOverlap(storeIn.addr, storeIn.size, entries[i].addr, entries[i].size)) begin
                storeHit = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < Depth; i++) begin
            killMask[i] = branchIn.taken && entValid[i] &&
                sqnDiff(entries[i].sqN, branchIn.sqN) >= 0;
        end
    end

    // Only the head may issue late. Non-speculative loads also wait for the commit point
    assign lateIssue = !branchIn.taken && entValid[headIdx] && !entIssued[headIdx] &&
        (!lateValid || !stall) &&
        (!entries[headIdx].nonSpec || (commitSqN == entries[headIdx].sqN && sqDone));

    // Retire a contiguous run of committed, issued entries from the head
    always_comb begin
        logic run;
        logic [IdxW-1:0] idx;
        run = !branchIn.taken && !lateIssue;
        retireMask = '0;
        retireCnt = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            idx = headIdx + IdxW'(i);
            if (run && entValid[idx] && entIssued[idx] &&
                sqnDiff(commitSqN, entries[idx].sqN) > 0) begin
                retireMask[idx] = 1'b1;
                retireCnt = retireCnt + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
    end

    always_comb begin
        if (branchIn.taken && branchIn.flush) begin
            headNext = branchIn.loadSqN;
        end else begin
            headNext = head + lsqPkg::sqN_t'(retireCnt);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            entIssued <= '0;
            head <= '0;
            maxLoadSqN <= lsqPkg::sqN_t'(Depth - 1);
            lateValid <= 1'b0;
            rollbackTaken <= 1'b0;
        end else begin
            if (!stall) begin
                lateValid <= 1'b0;
            end
            if (lateIssue) begin
                lateValid <= 1'b1;
                entIssued[headIdx] <= 1'b1;
            end
            // A failed access goes back to the late issue path
            if (ldAck.valid && ldAck.fail) begin
                entIssued[ackIdx] <= 1'b0;
            end
            entValid <= entValid & ~retireMask & ~killMask;
            if (branchIn.taken && lateValid && sqnDiff(lateUop.sqN, branchIn.sqN) >= 0) begin
                lateValid <= 1'b0;
            end
            if (insertEn) begin
                entValid[insIdx] <= 1'b1;
                entIssued[insIdx] <= !delayLoad;
            end
            head <= headNext;
            maxLoadSqN <= headNext + lsqPkg::sqN_t'(Depth - 1);
            rollbackTaken <= collisionNow;
        end
    end

    always_ff @(posedge clk) begin
        if (insertEn) begin
            entries[insIdx] <= '{
                sqN: loadIn.sqN,
                loadSqN: loadIn.loadSqN,
                tagDst: loadIn.tagDst,
                addr: loadIn.addr,
                size: loadIn.size,
                signExtend: loadIn.signExtend,
                nonSpec: inWindow
            };
        end
        if (lateIssue) begin
            lateUop <= '{
                valid: 1'b1,
                sqN: entries[headIdx].sqN,
                loadSqN: entries[headIdx].loadSqN,
                addr: entries[headIdx].addr,
                size: entries[headIdx].size,
                signExtend: entries[headIdx].signExtend,
                tagDst: entries[headIdx].tagDst,
                isMmio: entries[headIdx].nonSpec
            };
        end
        // Restart right after the store because its fetch state is the one we have
        if (collisionNow) begin
            rollback <= '{
                taken: 1'b1,
                flush: 1'b0,
                sqN: storeIn.sqN,
                loadSqN: storeIn.loadSqN,
                dstPc: storeIn.pc + (storeIn.compressed ? 32'd2 : 32'd4)
            };
        end
    end

    always_comb begin
        lateLoad = lateUop;
        lateLoad.valid = lateValid;
    end

    always_comb begin
        branchOut = rollback;
        branchOut.taken = rollbackTaken;
    end

endmodule

// File: design/lsqCtrlRegs.sv
`timescale 1ns/100ps
`include "lsq_consts.svh"

module lsqCtrlRegs (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  logic [31:0]      wdata,
    input  logic [3:0]       wstrb,
    input  logic             wvalid,
    output logic             wready,
    output lsqPkg::axiResp_e bresp,
    output logic             bvalid,
    input  logic             bready,
    input  logic [31:0]      araddr,
    input  logic             arvalid,
    output logic             arready,
    output logic [31:0]      rdata,
    output lsqPkg::axiResp_e rresp,
    output logic             rvalid,
    input  logic             rready,
    lsqCfgIf.regs            cfg
);

    logic [31:0] mmioBase;
    logic [31:0] mmioMask;
    logic [31:0] collCnt;
    logic [31:0] delayCnt;

    logic awHeld;
    logic wHeld;
    logic [31:0] awAddrQ;
    logic [31:0] wDataQ;
    logic [3:0] wStrbQ;

    logic awFire;
    logic wFire;
    logic arFire;
    logic awGot;
    logic wGot;
    logic doWrite;
    logic bvalidNext;
    logic rvalidNext;
    logic [31:0] wrAddr;
    logic [31:0] wrData;
    logic [3:0] wrStrb;
    lsqPkg::axiResp_e wrResp;
    logic [31:0] rdValue;
    lsqPkg::axiResp_e rdResp;

    function automatic logic [31:0] mergeStrb(
        input logic [31:0] old,
        input logic [31:0] data,
        input logic [3:0]  strb
    );
        logic [31:0] merged;
        for (int b = 0; b < 4; b++) begin
            merged[b*8 +: 8] = strb[b] ? data[b*8 +: 8] : old[b*8 +: 8];
        end
        return merged;
    endfunction

    // Counters stick at all ones instead of wrapping
    function automatic logic [31:0] satInc(input logic [31:0] cnt, input logic evt);
        return (evt && cnt != '1) ? cnt + 32'd1 : cnt;
    endfunction

    assign cfg.mmioBase = mmioBase;
    assign cfg.mmioMask = mmioMask;

    assign awFire = awvalid && awready;
    assign wFire = wvalid && wready;
    assign arFire = arvalid && arready;

    // AW and W may come in either order. The write happens once both are in
    assign awGot = awHeld || awFire;
    assign wGot = wHeld || wFire;
    assign doWrite = awGot && wGot;

    assign wrAddr = awFire ? awaddr : awAddrQ;
    assign wrData = wFire ? wdata : wDataQ;
    assign wrStrb = wFire ? wstrb : wStrbQ;

    assign bvalidNext = doWrite || (bvalid && !bready);
    assign rvalidNext = arFire || (rvalid && !rready);

    always_comb begin
        case (wrAddr)
            `REG_MMIO_BASE, `REG_MMIO_MASK, `REG_COLL_CNT, `REG_DELAY_CNT: wrResp = lsqPkg::OKAY;
            default: wrResp = lsqPkg::SLVERR;
        endcase
    end

    always_comb begin
        rdResp = lsqPkg::OKAY;
        case (araddr)
            `REG_MMIO_BASE: rdValue = mmioBase;
            `REG_MMIO_MASK: rdValue = mmioMask;
            `REG_COLL_CNT: rdValue = collCnt;
            `REG_DELAY_CNT: rdValue = delayCnt;
            default: begin
                rdValue = '0;
                rdResp = lsqPkg::SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awHeld <= 1'b0;
            wHeld <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            awHeld <= awGot && !doWrite;
            wHeld <= wGot && !doWrite;
            bvalid <= bvalidNext;
            rvalid <= rvalidNext;
            // Readies drop while a response is waiting for its handshake
            awready <= !(awGot && !doWrite) && !bvalidNext;
            wready <= !(wGot && !doWrite) && !bvalidNext;
            arready <= !rvalidNext;
        end
    end

    always_ff @(posedge clk) begin
        if (awFire) begin
            awAddrQ <= awaddr;
        end
        if (wFire) begin
            wDataQ <= wdata;
            wStrbQ <= wstrb;
        end
        if (doWrite) begin
            bresp <= wrResp;
        end
        if (arFire) begin
            rdata <= rdValue;
            rresp <= rdResp;
        end
    end

    // Window registers and event counters. Software cannot write the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            mmioBase <= '0;
            mmioMask <= '0;
            collCnt <= '0;
            delayCnt <= '0;
        end else begin
            if (doWrite && wrAddr == `REG_MMIO_BASE) begin
                mmioBase <= mergeStrb(mmioBase, wrData, wrStrb);
            end
            if (doWrite && wrAddr == `REG_MMIO_MASK) begin
                mmioMask <= mergeStrb(mmioMask, wrData, wrStrb);
            end
            collCnt <= satInc(collCnt, cfg.collisionEvt);
            delayCnt <= satInc(delayCnt, cfg.delayEvt);
        end
    end

endmodule

// File: design/loadStoreUnit.sv
`timescale 1ns/100ps

module loadStoreUnit (
    input  logic                clk,
    input  logic                rst,
    input  lsqPkg::sqN_t        commitSqN,
    input  logic                sqDone,
    input  logic                stall,
    input  lsqPkg::aguUop_t     loadIn,
    input  lsqPkg::aguUop_t     storeIn,
    input  lsqPkg::ldAck_t      ldAck,
    input  lsqPkg::branchProv_t branchIn,
    output lsqPkg::ldUop_t      aguLoad,
    output lsqPkg::ldUop_t      lateLoad,
    output logic                isDelayLoad,
    output lsqPkg::branchProv_t branchOut,
    output lsqPkg::sqN_t        maxLoadSqN,
    input  logic [31:0]         awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output lsqPkg::axiResp_e    bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [31:0]         araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output lsqPkg::axiResp_e    rresp,
    output logic                rvalid,
    input  logic                rready
);

    // Window settings go down to the buffer and event pulses come back up
    lsqCfgIf cfgBus ();

    loadBuffer buffer (
        .clk(clk),
        .rst(rst),
        .commitSqN(commitSqN),
        .sqDone(sqDone),
        .stall(stall),
        .loadIn(loadIn),
        .storeIn(storeIn),
        .ldAck(ldAck),
        .branchIn(branchIn),
        .aguLoad(aguLoad),
        .lateLoad(lateLoad),
        .isDelayLoad(isDelayLoad),
        .branchOut(branchOut),
        .maxLoadSqN(maxLoadSqN),
        .cfg(cfgBus.buffer)
    );

    lsqCtrlRegs regs (
        .clk(clk),
        .rst(rst),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .cfg(cfgBus.regs)
    );

endmodule

// File: dv/loadStoreTb.sv
`timescale 1ns/100ps
`include "lsq_consts.svh"

module loadStoreTb;

    localparam int WaitLimit = 40;

    logic clk;
    logic rst;
    lsqPkg::sqN_t commitSqN;
    logic sqDone;
    logic stall;
    lsqPkg::aguUop_t loadIn;
    lsqPkg::aguUop_t storeIn;
    lsqPkg::ldAck_t ldAck;
    lsqPkg::branchProv_t branchIn;
    lsqPkg::ldUop_t aguLoad;
    lsqPkg::ldUop_t lateLoad;
    logic isDelayLoad;
    lsqPkg::branchProv_t branchOut;
    lsqPkg::sqN_t maxLoadSqN;
    logic [31:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    lsqPkg::axiResp_e bresp;
    logic bvalid;
    logic bready;
    logic [31:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    lsqPkg::axiResp_e rresp;
    logic rvalid;
    logic rready;

    string testName = "startup";
    int errors = 0;
    int testErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;

    loadStoreUnit uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // A rollback request lasts exactly one cycle
    rollbackPulse: assert property (@(posedge clk) disable iff (rst)
        branchOut.taken |=> !branchOut.taken)
    else begin
        $display("[ERROR] %s: branchOut.taken stayed high for more than one cycle", testName);
        errors++;
    end

    delayedNotFast: assert property (@(posedge clk) disable iff (rst)
        isDelayLoad |-> !aguLoad.valid)
    else begin
        $display("[ERROR] %s: a delayed load also appeared on aguLoad", testName);
        errors++;
    end

    // The cache side may hold off a late load, which must then not change
    stallHolds: assert property (@(posedge clk) disable iff (rst)
        lateLoad.valid && stall |=> lateLoad.valid && $stable(lateLoad))
    else begin
        $display("[ERROR] %s: lateLoad changed or dropped while stall was high", testName);
        errors++;
    end

    task automatic startTest(input string name);
        testName = name;
        testErrors = errors;
    endtask

    task automatic endTest();
        testsRun++;
        if (errors == testErrors) begin
            $display("[PASS] %s", testName);
        end else begin
            testsFailed++;
            $display("[FAIL] %s with %0d errors", testName, errors - testErrors);
        end
    endtask

    task automatic checkVal(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: %s expected %0h, actual %0h", testName, what, expected, actual);
            errors++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("[ERROR] %s: timed out waiting for %s", testName, what);
        errors++;
    endtask

    task automatic step();
        @(negedge clk);
    endtask

    function automatic logic [31:0] randomAddr();
        logic [31:0] a;
        a = $urandom & 32'hFFFF_FFFC;
        // Keep clear of the MMIO window at 0x1xxx_xxxx
        if (a[31:28] == 4'h1) begin
            a[31:28] = 4'h2;
        end
        return a;
    endfunction

    function automatic lsqPkg::aguUop_t makeUop(
        input lsqPkg::sqN_t sqN,
        input lsqPkg::sqN_t loadSqN,
        input logic [31:0]  addr,
        input logic [1:0]   size,
        input logic [31:0]  pc,
        input logic         compressed
    );
        lsqPkg::aguUop_t u;
        u.valid = 1'b1;
        u.sqN = sqN;
        u.loadSqN = loadSqN;
        u.addr = addr;
        u.size = size;
        u.signExtend = (size != 2'd2);
        u.tagDst = {2'b00, loadSqN[3:0]};
        u.pc = pc;
        u.compressed = compressed;
        return u;
    endfunction

    // The cache request carries the load's fields unchanged
    function automatic lsqPkg::ldUop_t expectLd(input lsqPkg::aguUop_t u, input logic mmio);
        lsqPkg::ldUop_t l;
        l.valid = 1'b1;
        l.sqN = u.sqN;
        l.loadSqN = u.loadSqN;
        l.addr = u.addr;
        l.size = u.size;
        l.signExtend = u.signExtend;
        l.tagDst = u.tagDst;
        l.isMmio = mmio;
        return l;
    endfunction

    task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
                            output lsqPkg::axiResp_e resp);
        logic awHit;
        logic wHit;
        int n;
        awaddr = addr;
        wdata = data;
        wstrb = 4'hF;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b1;
        n = 0;
        while ((awvalid || wvalid) && n < WaitLimit) begin
            awHit = awvalid && awready;
            wHit = wvalid && wready;
            @(negedge clk);
            if (awHit) begin
                awvalid = 1'b0;
            end
            if (wHit) begin
                wvalid = 1'b0;
            end
            n++;
        end
        if (awvalid || wvalid) begin
            reportTimeout("the AW and W handshakes");
            awvalid = 1'b0;
            wvalid = 1'b0;
        end
        n = 0;
        while (!bvalid && n < WaitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) begin
            reportTimeout("bvalid");
        end
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [31:0] addr, output logic [31:0] data,
                           output lsqPkg::axiResp_e resp);
        logic arHit;
        int n;
        araddr = addr;
        arvalid = 1'b1;
        rready = 1'b1;
        n = 0;
        while (arvalid && n < WaitLimit) begin
            arHit = arready;
            @(negedge clk);
            if (arHit) begin
                arvalid = 1'b0;
            end
            n++;
        end
        if (arvalid) begin
            reportTimeout("the AR handshake");
            arvalid = 1'b0;
        end
        n = 0;
        while (!rvalid && n < WaitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid) begin
            reportTimeout("rvalid");
        end
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic waitLate();
        logic seen;
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WaitLimit) begin
            @(negedge clk);
            seen = lateLoad.valid;
            n++;
        end
        if (!seen) begin
            reportTimeout("a load on lateLoad");
        end
    endtask

    initial begin
        lsqPkg::axiResp_e resp;
        lsqPkg::aguUop_t ld;
        lsqPkg::branchProv_t expRb;
        lsqPkg::sqN_t maxBefore;
        logic [31:0] data;
        logic [31:0] addrA;
        int n;
        void'($urandom(32'h90e66c56));
        rst = 1'b1;
        commitSqN = '0;
        sqDone = 1'b0;
        stall = 1'b0;
        loadIn = '0;
        storeIn = '0;
        ldAck = '0;
        branchIn = '0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (8) @(negedge clk);

        startTest("reset");
        checkVal("awready", 0, awready);
        checkVal("wready", 0, wready);
        checkVal("arready", 0, arready);
        checkVal("bvalid", 0, bvalid);
        checkVal("rvalid", 0, rvalid);
        checkVal("branchOut.taken", 0, branchOut.taken);
        checkVal("lateLoad.valid", 0, lateLoad.valid);
        rst = 1'b0;
        endTest();

        startTest("configuration");
        axiWrite(`REG_MMIO_BASE, 32'h1000_0000, resp);
        checkVal("base write bresp", lsqPkg::OKAY, resp);
        axiWrite(`REG_MMIO_MASK, 32'hF000_0000, resp);
        checkVal("mask write bresp", lsqPkg::OKAY, resp);
        axiRead(`REG_MMIO_BASE, data, resp);
        checkVal("base readback", 32'h1000_0000, data);
        checkVal("base read rresp", lsqPkg::OKAY, resp);
        axiRead(`REG_MMIO_MASK, data, resp);
        checkVal("mask readback", 32'hF000_0000, data);
        checkVal("mask read rresp", lsqPkg::OKAY, resp);
        axiRead(32'h0000_0010, data, resp);
        checkVal("unmapped read rresp", lsqPkg::SLVERR, resp);
        endTest();

        startTest("fast issue");
        checkVal("maxLoadSqN", `LB_SIZE - 1, maxLoadSqN);
        ld = makeUop(7'd10, 7'd0, randomAddr(), 2'd2, 32'h8000_0000, 1'b0);
        loadIn = ld;
        #10;
        checkVal("aguLoad", expectLd(ld, 1'b0), aguLoad);
        checkVal("isDelayLoad", 0, isDelayLoad);
        step();
        loadIn = '0;
        endTest();

        startTest("mmio load");
        ld = makeUop(7'd11, 7'd1, 32'h1000_0040, 2'd2, 32'h8000_0010, 1'b0);
        loadIn = ld;
        #10;
        checkVal("isDelayLoad", 1, isDelayLoad);
        checkVal("aguLoad.valid", 0, aguLoad.valid);
        step();
        loadIn = '0;
        // The first load retires and the MMIO load reaches the head, but sqDone is still low
        commitSqN = 7'd11;
        axiRead(`REG_DELAY_CNT, data, resp);
        checkVal("delay counter", 1, data);
        checkVal("lateLoad.valid before commit", 0, lateLoad.valid);
        sqDone = 1'b1;
        waitLate();
        checkVal("lateLoad", expectLd(ld, 1'b1), lateLoad);
        stall = 1'b1;
        step();
        step();
        checkVal("lateLoad.valid under stall", 1, lateLoad.valid);
        stall = 1'b0;
        sqDone = 1'b0;
        // Retire the MMIO load so the next one lands at the head
        commitSqN = 7'd12;
        step();
        step();
        endTest();

        startTest("same-cycle overlap");
        addrA = randomAddr();
        storeIn = makeUop(7'd13, 7'd2, addrA + 32'd1, 2'd0, 32'h8000_0020, 1'b0);
        ld = makeUop(7'd16, 7'd2, addrA, 2'd2, 32'h8000_0030, 1'b0);
        loadIn = ld;
        #10;
        checkVal("isDelayLoad", 1, isDelayLoad);
        checkVal("aguLoad.valid", 0, aguLoad.valid);
        step();
        loadIn = '0;
        storeIn = '0;
        waitLate();
        checkVal("first late issue", expectLd(ld, 1'b0), lateLoad);
        ldAck = '{valid: 1'b1, fail: 1'b1, loadSqN: 7'd2};
        step();
        ldAck = '0;
        waitLate();
        checkVal("reissue after failed ack", expectLd(ld, 1'b0), lateLoad);
        endTest();

        startTest("store collision");
        storeIn = makeUop(7'd14, 7'd2, addrA + 32'd2, 2'd1, 32'h8000_0100, 1'b0);
        step();
        storeIn = '0;
        expRb = '{taken: 1'b1, flush: 1'b0, sqN: 7'd14, loadSqN: 7'd2, dstPc: 32'h8000_0104};
        checkVal("rollback", expRb, branchOut);
        step();
        checkVal("branchOut.taken after pulse", 0, branchOut.taken);
        storeIn = makeUop(7'd15, 7'd2, addrA + 32'd3, 2'd0, 32'h8000_0200, 1'b1);
        step();
        storeIn = '0;
        expRb = '{taken: 1'b1, flush: 1'b0, sqN: 7'd15, loadSqN: 7'd2, dstPc: 32'h8000_0202};
        checkVal("compressed rollback", expRb, branchOut);
        axiRead(`REG_COLL_CNT, data, resp);
        checkVal("collision counter", 2, data);
        endTest();

        startTest("retirement");
        loadIn = makeUop(7'd17, 7'd3, randomAddr(), 2'd2, 32'h8000_0300, 1'b0);
        #10;
        checkVal("aguLoad.valid", 1, aguLoad.valid);
        step();
        loadIn = makeUop(7'd18, 7'd4, randomAddr(), 2'd1, 32'h8000_0304, 1'b0);
        #10;
        checkVal("aguLoad.valid", 1, aguLoad.valid);
        step();
        loadIn = '0;
        // Loads 0 and 1 have retired, so the head sits at load 2
        checkVal("maxLoadSqN before commit", 2 + `LB_SIZE - 1, maxLoadSqN);
        maxBefore = maxLoadSqN;
        commitSqN = 7'd19;
        n = 0;
        while (maxLoadSqN == maxBefore && n < WaitLimit) begin
            step();
            n++;
        end
        if (maxLoadSqN == maxBefore) begin
            reportTimeout("maxLoadSqN to advance");
        end
        // Loads 2, 3 and 4 retire together and the head moves to load 5
        checkVal("maxLoadSqN after commit", 5 + `LB_SIZE - 1, maxLoadSqN);
        // Both loads behind the branch point must vanish
        loadIn = makeUop(7'd20, 7'd5, 32'h1000_0100, 2'd2, 32'h8000_0400, 1'b0);
        #10;
        checkVal("isDelayLoad", 1, isDelayLoad);
        step();
        loadIn = makeUop(7'd21, 7'd6, 32'h1000_0200, 2'd2, 32'h8000_0404, 1'b0);
        step();
        loadIn = '0;
        branchIn = '{taken: 1'b1, flush: 1'b1, sqN: 7'd20, loadSqN: 7'd5, dstPc: 32'h8000_0500};
        step();
        branchIn = '0;
        commitSqN = 7'd20;
        sqDone = 1'b1;
        repeat (6) begin
            step();
            checkVal("lateLoad.valid after branch", 0, lateLoad.valid);
        end
        sqDone = 1'b0;
        endTest();

        step();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+design
design/lsqPkg.sv
design/lsqCfgIf.sv
design/loadBuffer.sv
design/lsqCtrlRegs.sv
design/loadStoreUnit.sv
dv/loadStoreTb.sv
